//--- cpu_top.f
rtl/cpu_isa_pkg.sv
rtl/cpu_pipe_pkg.sv
rtl/mem_port_if.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/id_ex_register.sv
rtl/execute_stage.sv
rtl/shared_memory.sv
rtl/cpu_top.sv
tb/cpu_props.sv
tb/cpu_tb.sv

//--- rtl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count = 32;

    // Major opcodes of the supported RV32I subset.
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        load   = 7'b0000011,
        store  = 7'b0100011,
        branch = 7'b1100011,
        jal    = 7'b1101111
    } opcode_t;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_slt = 3'b010;
    localparam logic [2:0] funct3_xor = 3'b100;
    localparam logic [2:0] funct3_or = 3'b110;
    localparam logic [2:0] funct3_and = 3'b111;
    localparam logic [2:0] funct3_word = 3'b010; // LW and SW.
    localparam logic [2:0] funct3_beq = 3'b000;

    typedef enum logic [2:0] {
        add,
        sub,
        and_op,
        or_op,
        xor_op,
        slt,
        pass_b
    } alu_op_t;

    typedef enum logic {a_rs1, a_pc} operand_a_sel_t;
    typedef enum logic {b_rs2, b_imm} operand_b_sel_t;
    typedef enum logic [1:0] {sequential, branch_eq, jump} next_pc_sel_t;
    typedef enum logic {alu, memory} wb_sel_t;

endpackage

//--- rtl/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

    localparam int mem_words = 1024;
    localparam int mem_addr_width = 10; // Word address.

    // Decoded instruction as it travels from decode into execute.
    typedef struct packed {
        logic [cpu_isa_pkg::xlen-1:0] pc;
        logic [cpu_isa_pkg::xlen-1:0] rs1_data;
        logic [cpu_isa_pkg::xlen-1:0] rs2_data;
        logic [cpu_isa_pkg::xlen-1:0] imm;
        logic [cpu_isa_pkg::reg_addr_width-1:0] rs1_addr;
        logic [cpu_isa_pkg::reg_addr_width-1:0] rs2_addr;
        logic [cpu_isa_pkg::reg_addr_width-1:0] rd_addr;
        cpu_isa_pkg::alu_op_t alu_op;
        cpu_isa_pkg::operand_a_sel_t a_sel;
        cpu_isa_pkg::operand_b_sel_t b_sel;
        cpu_isa_pkg::next_pc_sel_t next_pc_sel;
        cpu_isa_pkg::wb_sel_t wb_sel;
        logic reg_write_enable;
        logic mem_write_enable;
        logic mem_read_enable;
        logic valid;
    } id_ex_t;

    // What the writeback stage needs from execute.
    typedef struct packed {
        logic [cpu_isa_pkg::reg_addr_width-1:0] rd_addr;
        logic [cpu_isa_pkg::xlen-1:0] alu_result;
        cpu_isa_pkg::wb_sel_t wb_sel;
        logic reg_write_enable;
        logic valid;
    } ex_wb_t;

endpackage

//--- rtl/cpu_top.sv
module cpu_top (
    input logic clk,
    input logic reset_n,
    input logic start,
    input logic host_req,
    input logic host_we,
    input logic [cpu_pipe_pkg::mem_addr_width-1:0] host_addr,
    input logic [cpu_isa_pkg::xlen-1:0] host_wdata,
    output logic [cpu_isa_pkg::xlen-1:0] host_rdata,
    output logic retire_valid,
    output logic [cpu_isa_pkg::reg_addr_width-1:0] retire_rd,
    output logic [cpu_isa_pkg::xlen-1:0] retire_data
);

    mem_port_if host_port ();
    mem_port_if data_port ();
    mem_port_if fetch_port ();

    logic running;
    logic redirect, flush;
    logic [cpu_isa_pkg::xlen-1:0] redirect_pc;
    logic [cpu_isa_pkg::xlen-1:0] if_instr, if_pc;
    logic if_valid;
    logic wb_enable;
    logic [cpu_isa_pkg::reg_addr_width-1:0] wb_rd;
    logic [cpu_isa_pkg::xlen-1:0] wb_data;
    cpu_pipe_pkg::id_ex_t id_out, id_ex;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            running <= 1'b0;
        end else if (start) begin
            running <= 1'b1; // Held until the next reset.
        end
    end

    assign host_port.req = host_req;
    assign host_port.we = host_we;
    assign host_port.addr = host_addr;
    assign host_port.wdata = host_wdata;
    assign host_rdata = host_port.rdata;

    fetch_unit i_fetch_unit (
        .clk(clk), .reset_n(reset_n), .running(running), .redirect(redirect),
        .redirect_pc(redirect_pc), .fetch_port(fetch_port.requester),
        .if_instr(if_instr), .if_pc(if_pc), .if_valid(if_valid)
    );

    decode_stage i_decode_stage (
        .clk(clk), .reset_n(reset_n), .if_instr(if_instr), .if_pc(if_pc),
        .if_valid(if_valid), .wb_enable(wb_enable), .wb_rd(wb_rd), .wb_data(wb_data),
        .id_out(id_out)
    );

    id_ex_register i_id_ex_register (
        .clk(clk), .reset_n(reset_n), .write_enable(running), .flush(flush),
        .id_in(id_out), .id_ex(id_ex)
    );

    execute_stage i_execute_stage (
        .clk(clk), .reset_n(reset_n), .id_ex(id_ex), .data_port(data_port.requester),
        .redirect(redirect), .redirect_pc(redirect_pc), .flush(flush),
        .wb_enable(wb_enable), .wb_rd(wb_rd), .wb_data(wb_data),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    shared_memory i_shared_memory (
        .clk(clk), .host_port(host_port.memory), .data_port(data_port.memory),
        .fetch_port(fetch_port.memory)
    );

endmodule

//--- rtl/decode_stage.sv
module decode_stage (
    input logic clk,
    input logic reset_n,
    input logic [cpu_isa_pkg::xlen-1:0] if_instr,
    input logic [cpu_isa_pkg::xlen-1:0] if_pc,
    input logic if_valid,
    input logic wb_enable,
    input logic [cpu_isa_pkg::reg_addr_width-1:0] wb_rd,
    input logic [cpu_isa_pkg::xlen-1:0] wb_data,
    output cpu_pipe_pkg::id_ex_t id_out
);

    logic [cpu_isa_pkg::xlen-1:0] regs [cpu_isa_pkg::reg_count];
    logic [cpu_isa_pkg::reg_addr_width-1:0] rs1;
    logic [cpu_isa_pkg::reg_addr_width-1:0] rs2;
    logic [2:0] funct3;
    logic known;
    logic [cpu_isa_pkg::xlen-1:0] imm_i, imm_s, imm_b, imm_j, imm_u;

    assign rs1 = if_instr[19:15];
    assign rs2 = if_instr[24:20];
    assign funct3 = if_instr[14:12];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_j = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12], if_instr[20],
                    if_instr[30:21], 1'b0};
    assign imm_u = {if_instr[31:12], 12'b0};

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < cpu_isa_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_comb begin
        id_out = '0;
        known = 1'b1;
        id_out.pc = if_pc;
        id_out.rs1_addr = rs1;
        id_out.rs2_addr = rs2;
        id_out.rd_addr = if_instr[11:7];
        // A writeback in this same cycle passes straight to the read.
        id_out.rs1_data = (rs1 == '0) ? '0 : (wb_enable && wb_rd == rs1) ? wb_data : regs[rs1];
        id_out.rs2_data = (rs2 == '0) ? '0 : (wb_enable && wb_rd == rs2) ? wb_data : regs[rs2];
        id_out.alu_op = cpu_isa_pkg::add;
        id_out.a_sel = cpu_isa_pkg::a_rs1;
        id_out.b_sel = cpu_isa_pkg::b_imm;
        id_out.next_pc_sel = cpu_isa_pkg::sequential;
        id_out.wb_sel = cpu_isa_pkg::alu;
        case (if_instr[6:0])
            cpu_isa_pkg::op: begin
                id_out.b_sel = cpu_isa_pkg::b_rs2;
                id_out.reg_write_enable = 1'b1;
                case (funct3)
                    cpu_isa_pkg::funct3_add_sub:
                        id_out.alu_op = if_instr[30] ? cpu_isa_pkg::sub : cpu_isa_pkg::add;
                    cpu_isa_pkg::funct3_slt: id_out.alu_op = cpu_isa_pkg::slt;
                    cpu_isa_pkg::funct3_xor: id_out.alu_op = cpu_isa_pkg::xor_op;
                    cpu_isa_pkg::funct3_or: id_out.alu_op = cpu_isa_pkg::or_op;
                    cpu_isa_pkg::funct3_and: id_out.alu_op = cpu_isa_pkg::and_op;
                    default: known = 1'b0;
                endcase
            end
            cpu_isa_pkg::op_imm: begin
                id_out.imm = imm_i;
                id_out.reg_write_enable = 1'b1;
                known = (funct3 == cpu_isa_pkg::funct3_add_sub); // Only ADDI.
            end
            cpu_isa_pkg::lui: begin
                id_out.imm = imm_u;
                id_out.alu_op = cpu_isa_pkg::pass_b;
                id_out.reg_write_enable = 1'b1;
            end
            cpu_isa_pkg::load: begin
                id_out.imm = imm_i;
                id_out.wb_sel = cpu_isa_pkg::memory;
                id_out.reg_write_enable = 1'b1;
                id_out.mem_read_enable = 1'b1;
                known = (funct3 == cpu_isa_pkg::funct3_word);
            end
            cpu_isa_pkg::store: begin
                id_out.imm = imm_s;
                id_out.mem_write_enable = 1'b1;
                known = (funct3 == cpu_isa_pkg::funct3_word);
            end
            cpu_isa_pkg::branch: begin
                id_out.imm = imm_b;
                id_out.b_sel = cpu_isa_pkg::b_rs2;
                id_out.alu_op = cpu_isa_pkg::sub;
                id_out.next_pc_sel = cpu_isa_pkg::branch_eq;
                known = (funct3 == cpu_isa_pkg::funct3_beq);
            end
            cpu_isa_pkg::jal: begin
                id_out.imm = imm_j;
                id_out.a_sel = cpu_isa_pkg::a_pc;
                id_out.next_pc_sel = cpu_isa_pkg::jump;
                id_out.reg_write_enable = 1'b1;
            end
            default: known = 1'b0;
        endcase
        id_out.valid = if_valid && known;
    end

endmodule

//--- rtl/execute_stage.sv
module execute_stage (
    input logic clk,
    input logic reset_n,
    input cpu_pipe_pkg::id_ex_t id_ex,
    mem_port_if.requester data_port,
    output logic redirect,
    output logic [cpu_isa_pkg::xlen-1:0] redirect_pc,
    output logic flush,
    output logic wb_enable,
    output logic [cpu_isa_pkg::reg_addr_width-1:0] wb_rd,
    output logic [cpu_isa_pkg::xlen-1:0] wb_data,
    output logic retire_valid,
    output logic [cpu_isa_pkg::reg_addr_width-1:0] retire_rd,
    output logic [cpu_isa_pkg::xlen-1:0] retire_data
);

    cpu_pipe_pkg::ex_wb_t ex_wb;
    cpu_pipe_pkg::ex_wb_t ex_next;
    logic [cpu_isa_pkg::xlen-1:0] rs1_value, rs2_value;
    logic [cpu_isa_pkg::xlen-1:0] alu_a, alu_b, alu_result;
    logic [cpu_isa_pkg::xlen-1:0] target;
    logic taken;

    // Writeback side. Load data arrives on rdata in this cycle.
    assign wb_enable = ex_wb.valid && ex_wb.reg_write_enable && ex_wb.rd_addr != '0;
    assign wb_rd = ex_wb.rd_addr;
    assign wb_data = (ex_wb.wb_sel == cpu_isa_pkg::memory) ? data_port.rdata : ex_wb.alu_result;

    assign retire_valid = wb_enable;
    assign retire_rd = wb_rd;
    assign retire_data = wb_data;

    // The instruction one ahead is in writeback; older ones come through the register file.
    assign rs1_value = (wb_enable && wb_rd == id_ex.rs1_addr) ? wb_data : id_ex.rs1_data;
    assign rs2_value = (wb_enable && wb_rd == id_ex.rs2_addr) ? wb_data : id_ex.rs2_data;

    assign alu_a = (id_ex.a_sel == cpu_isa_pkg::a_pc) ? id_ex.pc : rs1_value;
    assign alu_b = (id_ex.b_sel == cpu_isa_pkg::b_imm) ? id_ex.imm : rs2_value;

    always_comb begin
        case (id_ex.alu_op)
            cpu_isa_pkg::add: alu_result = alu_a + alu_b;
            cpu_isa_pkg::sub: alu_result = alu_a - alu_b;
            cpu_isa_pkg::and_op: alu_result = alu_a & alu_b;
            cpu_isa_pkg::or_op: alu_result = alu_a | alu_b;
            cpu_isa_pkg::xor_op: alu_result = alu_a ^ alu_b;
            cpu_isa_pkg::slt: alu_result = {{(cpu_isa_pkg::xlen-1){1'b0}},
                                            $signed(alu_a) < $signed(alu_b)};
            cpu_isa_pkg::pass_b: alu_result = alu_b;
            default: alu_result = '0;
        endcase
    end

    assign target = id_ex.pc + id_ex.imm;

    always_comb begin
        case (id_ex.next_pc_sel)
            cpu_isa_pkg::branch_eq: taken = (rs1_value == rs2_value);
            cpu_isa_pkg::jump: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = id_ex.valid && taken;
    assign redirect_pc = target;
    assign flush = redirect; // Kills the instruction now in decode.

    assign data_port.req = id_ex.valid && (id_ex.mem_read_enable || id_ex.mem_write_enable);
    assign data_port.we = id_ex.valid && id_ex.mem_write_enable;
    assign data_port.addr = alu_result[cpu_pipe_pkg::mem_addr_width+1:2];
    assign data_port.wdata = rs2_value;

    always_comb begin
        ex_next.rd_addr = id_ex.rd_addr;
        ex_next.alu_result = (id_ex.next_pc_sel == cpu_isa_pkg::jump) ? id_ex.pc + 32'd4
                                                                       : alu_result;
        ex_next.wb_sel = id_ex.wb_sel;
        ex_next.reg_write_enable = id_ex.reg_write_enable;
        ex_next.valid = id_ex.valid;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ex_wb <= '0;
        end else begin
            ex_wb <= ex_next;
        end
    end

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit (
    input logic clk,
    input logic reset_n,
    input logic running,
    input logic redirect,
    input logic [cpu_isa_pkg::xlen-1:0] redirect_pc,
    mem_port_if.requester fetch_port,
    output logic [cpu_isa_pkg::xlen-1:0] if_instr,
    output logic [cpu_isa_pkg::xlen-1:0] if_pc,
    output logic if_valid
);

    logic [cpu_isa_pkg::xlen-1:0] pc;
    logic [cpu_isa_pkg::xlen-1:0] pending_pc;
    logic pending_valid;

    // Fetch asks every running cycle and retries the same pc when it loses.
    assign fetch_port.req = running;
    assign fetch_port.we = 1'b0;
    assign fetch_port.addr = pc[cpu_pipe_pkg::mem_addr_width+1:2];
    assign fetch_port.wdata = '0;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc <= '0;
            pending_valid <= 1'b0;
        end else if (redirect) begin
            pc <= redirect_pc;
            pending_valid <= 1'b0; // The word on its way back is wrong path.
        end else begin
            if (fetch_port.gnt) begin
                pc <= pc + 32'd4;
            end
            pending_valid <= fetch_port.gnt;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_port.gnt) begin
            pending_pc <= pc;
        end
    end

    // The memory's registered read data forms the instruction half of IF/ID.
    assign if_instr = fetch_port.rdata;
    assign if_pc = pending_pc;
    assign if_valid = pending_valid;

endmodule

//--- rtl/id_ex_register.sv
module id_ex_register (
    input logic clk,
    input logic reset_n,
    input logic write_enable,
    input logic flush,
    input cpu_pipe_pkg::id_ex_t id_in,
    output cpu_pipe_pkg::id_ex_t id_ex
);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            id_ex <= '0;
        end else if (write_enable) begin
            if (flush) begin
                id_ex <= '0; // Bubble in place of the wrong-path instruction.
            end else begin
                id_ex <= id_in;
            end
        end
    end

endmodule

//--- rtl/mem_port_if.sv
interface mem_port_if;

    logic req;
    logic we;
    logic [cpu_pipe_pkg::mem_addr_width-1:0] addr;
    logic [cpu_isa_pkg::xlen-1:0] wdata;
    logic [cpu_isa_pkg::xlen-1:0] rdata; // Valid the cycle after a granted read.
    logic gnt; // Same cycle as req.

    modport requester (
        output req, we, addr, wdata,
        input rdata, gnt
    );

    modport memory (
        input req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

//--- rtl/shared_memory.sv
module shared_memory (
    input logic clk,
    mem_port_if.memory host_port,
    mem_port_if.memory data_port,
    mem_port_if.memory fetch_port
);

    logic [cpu_isa_pkg::xlen-1:0] mem [cpu_pipe_pkg::mem_words];
    logic [cpu_pipe_pkg::mem_addr_width-1:0] sel_addr;
    logic [cpu_isa_pkg::xlen-1:0] sel_wdata;
    logic sel_we;

    // Host first, then load/store, then fetch.
    assign host_port.gnt = host_port.req;
    assign data_port.gnt = data_port.req && !host_port.req;
    assign fetch_port.gnt = fetch_port.req && !host_port.req && !data_port.req;

    always_comb begin
        if (host_port.req) begin
            sel_addr = host_port.addr;
            sel_we = host_port.we;
            sel_wdata = host_port.wdata;
        end else if (data_port.req) begin
            sel_addr = data_port.addr;
            sel_we = data_port.we;
            sel_wdata = data_port.wdata;
        end else begin
            sel_addr = fetch_port.addr;
            sel_we = fetch_port.we && fetch_port.req;
            sel_wdata = fetch_port.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
        // Only the granted reader sees new data, the others hold theirs.
        if (host_port.gnt && !host_port.we) begin
            host_port.rdata <= mem[sel_addr];
        end
        if (data_port.gnt && !data_port.we) begin
            data_port.rdata <= mem[sel_addr];
        end
        if (fetch_port.gnt && !fetch_port.we) begin
            fetch_port.rdata <= mem[sel_addr];
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f cpu_top.f -o sim_cpu \
    && ./obj_dir/sim_cpu | tee /dev/stderr | grep -qx "Simulation passed" \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

//--- tb/cpu_props.sv
module cpu_props (
    input logic clk,
    input logic reset_n,
    input logic running,
    input logic host_gnt,
    input logic data_gnt,
    input logic fetch_gnt,
    input logic retire_valid,
    input logic [cpu_isa_pkg::reg_addr_width-1:0] retire_rd,
    input logic redirect,
    input logic id_ex_valid
);

    int failures = 0; // Read by the testbench.

    one_grant: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({host_gnt, data_gnt, fetch_gnt}))
        else begin
            failures++;
            $error("More than one memory grant in one cycle.");
        end

    idle_no_retire: assert property (@(posedge clk) disable iff (!reset_n)
        !running |-> !retire_valid)
        else begin
            failures++;
            $error("Retirement while the core is idle.");
        end

    retire_rd_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
        retire_valid |-> retire_rd != '0)
        else begin
            failures++;
            $error("Retirement to register 0.");
        end

    // The instruction behind a taken branch or jump becomes a bubble.
    redirect_flushes: assert property (@(posedge clk) disable iff (!reset_n)
        redirect |=> !id_ex_valid)
        else begin
            failures++;
            $error("Valid ID/EX entry right after a redirect.");
        end

endmodule

bind cpu_top cpu_props i_cpu_props (
    .clk(clk), .reset_n(reset_n), .running(running), .host_gnt(host_port.gnt),
    .data_gnt(data_port.gnt), .fetch_gnt(fetch_port.gnt), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .redirect(redirect), .id_ex_valid(id_ex.valid)
);

//--- tb/cpu_tb.sv
module cpu_tb;

    localparam int prog_rows = 26;
    localparam int mem_checks = 5;
    localparam int halt_watch_cycles = 40;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;

    logic clk = 1'b0;
    logic reset_n;
    logic start;
    logic host_req;
    logic host_we;
    logic [cpu_pipe_pkg::mem_addr_width-1:0] host_addr;
    logic [cpu_isa_pkg::xlen-1:0] host_wdata;
    logic [cpu_isa_pkg::xlen-1:0] host_rdata;
    logic retire_valid;
    logic [cpu_isa_pkg::reg_addr_width-1:0] retire_rd;
    logic [cpu_isa_pkg::xlen-1:0] retire_data;

    // One row per program word; no_retire marks wrong-path rows and rows without a write.
    logic [cpu_isa_pkg::xlen-1:0] prog_instr [prog_rows];
    logic [cpu_isa_pkg::reg_addr_width-1:0] prog_rd [prog_rows];
    logic [cpu_isa_pkg::xlen-1:0] prog_value [prog_rows];
    int row_count = 0;
    int retire_rows [$];
    int retire_pos = 0;
    logic [cpu_pipe_pkg::mem_addr_width-1:0] mem_check_addr [mem_checks];
    logic [cpu_isa_pkg::xlen-1:0] mem_check_word [mem_checks];
    logic [cpu_isa_pkg::xlen-1:0] read_data;
    bit started = 1'b0;
    int errors = 0;

    cpu_top i_cpu_top (
        .clk(clk), .reset_n(reset_n), .start(start), .host_req(host_req),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .retire_valid(retire_valid), .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] encode_r(input int funct7, input int rs2, input int rs1,
                                             input int funct3, input int rd);
        encode_r = {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input int imm, input int rs1, input int funct3,
                                             input int rd, input logic [6:0] opcode);
        encode_i = {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] encode_s(input int imm, input int rs2, input int rs1);
        encode_s = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_b(input int imm, input int rs2, input int rs1);
        encode_b = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11],
                    7'b1100011};
    endfunction

    function automatic logic [31:0] encode_u(input int imm20, input int rd);
        encode_u = {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] encode_j(input int imm, input int rd);
        encode_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic report_failure(input string what);
        errors++;
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error.");
    endtask

    task automatic check_retire(input logic [cpu_isa_pkg::reg_addr_width-1:0] exp_rd,
                                input logic [cpu_isa_pkg::reg_addr_width-1:0] got_rd,
                                input logic [cpu_isa_pkg::xlen-1:0] exp_data,
                                input logic [cpu_isa_pkg::xlen-1:0] got_data);
        if (got_rd !== exp_rd) begin
            report_failure($sformatf("CHECK FAILED retire_rd: expected %h, got %h",
                                     exp_rd, got_rd));
        end
        if (got_data !== exp_data) begin
            report_failure($sformatf("CHECK FAILED retire_data (x%0d): expected %h, got %h",
                                     exp_rd, exp_data, got_data));
        end
    endtask

    task automatic check_mem_word(input logic [cpu_pipe_pkg::mem_addr_width-1:0] addr,
                                  input logic [cpu_isa_pkg::xlen-1:0] exp_word,
                                  input logic [cpu_isa_pkg::xlen-1:0] got_word);
        if (got_word !== exp_word) begin
            report_failure($sformatf("CHECK FAILED host_rdata at %h: expected %h, got %h",
                                     addr, exp_word, got_word));
        end
    endtask

    task automatic add_row(input logic [31:0] instr, input int rd, input logic [31:0] value,
                           input bit no_retire);
        prog_instr[row_count] = instr;
        prog_rd[row_count] = rd[4:0];
        prog_value[row_count] = value;
        if (!no_retire) begin
            retire_rows.push_back(row_count);
        end
        row_count++;
    endtask

    task automatic build_program();
        add_row(encode_i(12, 0, 0, 1, opc_op_imm), 1, 32'h0000000c, 1'b0);
        add_row(encode_i(-3, 0, 0, 2, opc_op_imm), 2, 32'hfffffffd, 1'b0);
        add_row(encode_r(0, 2, 1, 0, 3), 3, 32'h00000009, 1'b0);   // ADD
        add_row(encode_r(32, 2, 1, 0, 4), 4, 32'h0000000f, 1'b0);  // SUB
        add_row(encode_r(0, 4, 3, 7, 5), 5, 32'h00000009, 1'b0);   // AND
        add_row(encode_r(0, 2, 5, 6, 6), 6, 32'hfffffffd, 1'b0);   // OR
        add_row(encode_r(0, 1, 6, 4, 7), 7, 32'hfffffff1, 1'b0);   // XOR
        add_row(encode_r(0, 1, 7, 2, 8), 8, 32'h00000001, 1'b0);   // SLT, -15 < 12.
        add_row(encode_u(32'h12345, 9), 9, 32'h12345000, 1'b0);
        add_row(encode_i(32'h678, 9, 0, 9, opc_op_imm), 9, 32'h12345678, 1'b0);
        add_row(encode_s(32'h200, 9, 0), 0, 32'h0, 1'b1);
        add_row(encode_i(1, 9, 0, 0, opc_op_imm), 0, 32'h0, 1'b1);
        add_row(encode_i(32'h200, 0, 2, 10, opc_load), 10, 32'h12345678, 1'b0);
        add_row(encode_r(0, 1, 10, 0, 11), 11, 32'h12345684, 1'b0); // Uses the load in WB.
        add_row(encode_r(0, 8, 0, 0, 12), 12, 32'h00000001, 1'b0);
        add_row(encode_b(12, 12, 8), 0, 32'h0, 1'b1);              // Taken, to pc 72.
        add_row(encode_i(32'h111, 0, 0, 13, opc_op_imm), 13, 32'h111, 1'b1);
        add_row(encode_i(32'h222, 0, 0, 14, opc_op_imm), 14, 32'h222, 1'b1);
        add_row(encode_b(8, 2, 1), 0, 32'h0, 1'b1);                // Not taken.
        add_row(encode_i(32'h77, 0, 0, 15, opc_op_imm), 15, 32'h00000077, 1'b0);
        add_row(encode_j(12, 16), 16, 32'h00000054, 1'b0);         // Link is 80 + 4.
        add_row(encode_i(32'h333, 0, 0, 17, opc_op_imm), 17, 32'h333, 1'b1);
        add_row(encode_i(32'h444, 0, 0, 18, opc_op_imm), 18, 32'h444, 1'b1);
        add_row(encode_s(32'h204, 11, 0), 0, 32'h0, 1'b1);
        add_row(encode_r(0, 15, 16, 0, 19), 19, 32'h000000cb, 1'b0);
        add_row(encode_j(0, 0), 0, 32'h0, 1'b1);                   // Halt on itself.
        mem_check_addr[0] = 10'h080;
        mem_check_word[0] = 32'h12345678;
        mem_check_addr[1] = 10'h081;
        mem_check_word[1] = 32'h12345684;
        mem_check_addr[2] = 10'h000;
        mem_check_word[2] = prog_instr[0];
        mem_check_addr[3] = 10'h00a;
        mem_check_word[3] = prog_instr[10];
        mem_check_addr[4] = 10'h019;
        mem_check_word[4] = prog_instr[25];
    endtask

    task automatic read_word(input logic [cpu_pipe_pkg::mem_addr_width-1:0] addr,
                             output logic [cpu_isa_pkg::xlen-1:0] data);
        @(posedge clk);
        host_req <= 1'b1;
        host_we <= 1'b0;
        host_addr <= addr;
        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        data = host_rdata; // Registered one cycle after the request.
    endtask

    // Retirements are matched in table order. Sampled mid-cycle.
    always @(negedge clk) begin
        if (i_cpu_top.i_cpu_props.failures != 0) begin
            report_failure("An assertion in cpu_props failed.");
        end
        if (!started) begin
            if (retire_valid !== 1'b0) begin
                report_failure("retire_valid was not low before start.");
            end
        end else if (retire_valid === 1'b1) begin
            if (retire_pos >= retire_rows.size()) begin
                report_failure("A retirement appeared after the last expected one.");
            end else begin
                check_retire(prog_rd[retire_rows[retire_pos]], retire_rd,
                             prog_value[retire_rows[retire_pos]], retire_data);
                retire_pos++;
            end
        end
    end

    initial begin
        repeat (prog_rows * 20) @(posedge clk);
        report_failure($sformatf("Timeout: the run did not finish in %0d cycles.",
                                 prog_rows * 20));
    end

    initial begin
        reset_n = 1'b0;
        start = 1'b0;
        host_req = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        build_program();
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
        for (int i = 0; i < prog_rows; i++) begin
            @(posedge clk);
            host_req <= 1'b1;
            host_we <= 1'b1;
            host_addr <= i[cpu_pipe_pkg::mem_addr_width-1:0];
            host_wdata <= prog_instr[i];
        end
        @(posedge clk);
        host_req <= 1'b0;
        host_we <= 1'b0;
        @(posedge clk);
        start <= 1'b1;
        started = 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (retire_pos < retire_rows.size()) begin
            @(posedge clk);
        end
        repeat (halt_watch_cycles) @(posedge clk); // The core spins on the halt jump here.
        for (int i = 0; i < mem_checks; i++) begin
            read_word(mem_check_addr[i], read_data);
            check_mem_word(mem_check_addr[i], mem_check_word[i], read_data);
        end
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
